// ==== Bender.yml ====
package:
  name: multilane_pcs_tx

sources:
  - files:
      - logic/pcs_pkg.sv
      - logic/serdes_pkg.sv
      - logic/gearbox_33_to_32.sv
      - logic/tx_block_feeder.sv
      - logic/tx_lane.sv
      - logic/tx_lane_bond.sv
      - logic/multilane_pcs_tx.sv
  - target: simulation
    files:
      - dv/tb_multilane_pcs_tx.sv

// ==== build.f ====
logic/pcs_pkg.sv
logic/serdes_pkg.sv
logic/gearbox_33_to_32.sv
logic/tx_block_feeder.sv
logic/tx_lane.sv
logic/tx_lane_bond.sv
logic/multilane_pcs_tx.sv
dv/tb_multilane_pcs_tx.sv

// ==== dv/tb_multilane_pcs_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_multilane_pcs_tx;

	import pcs_pkg::*;
	import serdes_pkg::*;

	localparam int LANES        = 4;
	localparam int CLK_PERIOD   = 40;
	localparam int RESET_CYCLES = 16;
	// Request cycle to first bonded word
	localparam int OUT_LATENCY  = 5;
	localparam int REQ_TIMEOUT  = 10;
	// Circular bit store per lane, far deeper than the pipeline lag
	localparam int STREAM_DEPTH = 4096;

	localparam int MODE_ZERO = 0;
	localparam int MODE_RAND = 1;
	localparam int MODE_SAME = 2;
	localparam int HDR_DATA  = 0;
	localparam int HDR_CTRL  = 1;
	localparam int HDR_MIXED = 2;

	localparam int NUM_ROWS     = 5;
	localparam int CHANGED_LANE = 2;

	logic                       clk;
	logic                       rst_n;
	block_header_t  [LANES-1:0] block_header;
	block_payload_t [LANES-1:0] block_payload;
	logic           [LANES-1:0] polarity_inv;
	logic                       block_req;
	serdes_word_t   [LANES-1:0] serdes_data;

	// Stimulus table, one entry per row
	string            row_name   [NUM_ROWS];
	int               row_mode   [NUM_ROWS];
	int               row_hdr    [NUM_ROWS];
	logic [LANES-1:0] row_mask   [NUM_ROWS];
	int               row_blocks [NUM_ROWS];

	int                      errors;
	int                      checks;
	int                      cycle;
	int                      first_req_cycle;
	int                      req_in_window;
	logic                    req_prev;
	logic                    aborted;
	int                      row;
	int                      blocks_sent;
	int                      wait_cnt;
	logic [31:0]             lcg_state;
	// Reference scrambler history and expected bitstream per lane
	scram_state_t            model_scram [LANES];
	logic [STREAM_DEPTH-1:0] stream_bits [LANES];
	int                      wr_ptr      [LANES];
	int                      rd_ptr      [LANES];

	multilane_pcs_tx #(
		.LANES (LANES)
	) u_multilane_pcs_tx (
		.clk           (clk),
		.rst_n         (rst_n),
		.block_header  (block_header),
		.block_payload (block_payload),
		.polarity_inv  (polarity_inv),
		.block_req     (block_req),
		.serdes_data   (serdes_data)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#(CLK_PERIOD / 2) clk = ~clk;
		end
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic draw_random(output logic [63:0] value);
		logic [31:0] upper;
		lcg_state = lcg_next(lcg_state);
		upper     = lcg_state;
		lcg_state = lcg_next(lcg_state);
		value     = {upper, lcg_state};
	endtask

	task automatic load_table();
		// Three frames of zeros show the all-ones history
		row_name[0] = "zero_payload";
		row_mode[0] = MODE_ZERO;
		row_hdr[0]  = HDR_DATA;
		row_mask[0] = 4'b0000;
		row_blocks[0] = 3 * FRAME_BLOCKS;
		row_name[1] = "random_mixed";
		row_mode[1] = MODE_RAND;
		row_hdr[1]  = HDR_MIXED;
		row_mask[1] = 4'b0000;
		row_blocks[1] = 3 * FRAME_BLOCKS;
		row_name[2] = "polarity_random";
		row_mode[2] = MODE_RAND;
		row_hdr[2]  = HDR_MIXED;
		row_mask[2] = 4'b1010;
		row_blocks[2] = 2 * FRAME_BLOCKS;
		row_name[3] = "polarity_zero_ctrl";
		row_mode[3] = MODE_ZERO;
		row_hdr[3]  = HDR_CTRL;
		row_mask[3] = 4'b1010;
		row_blocks[3] = FRAME_BLOCKS;
		// Lane 2 changes its payload halfway through
		row_name[4] = "lane_independence";
		row_mode[4] = MODE_SAME;
		row_hdr[4]  = HDR_DATA;
		row_mask[4] = 4'b0000;
		row_blocks[4] = 2 * FRAME_BLOCKS;
	endtask

	// Line order is header bit 0, header bit 1, then scrambled payload from bit 0
	task automatic push_block(input int lane, input block_header_t hdr,
			input block_payload_t pay);
		logic sbit;
		for (int k = 0; k < HEADER_WIDTH; k++) begin
			stream_bits[lane][wr_ptr[lane] % STREAM_DEPTH] = hdr[k];
			wr_ptr[lane]++;
		end
		for (int k = 0; k < PAYLOAD_WIDTH; k++) begin
			// x^58 + x^39 + 1 over past scrambled bits
			sbit = pay[k] ^ model_scram[lane][38] ^ model_scram[lane][57];
			model_scram[lane] = {model_scram[lane][SCRAM_WIDTH-2:0], sbit};
			stream_bits[lane][wr_ptr[lane] % STREAM_DEPTH] = sbit;
			wr_ptr[lane]++;
		end
	endtask

	// Earliest bit lands in bit 0
	task automatic pop_word(input int lane, output serdes_word_t word);
		for (int k = 0; k < SERDES_WIDTH; k++) begin
			word[k] = stream_bits[lane][rd_ptr[lane] % STREAM_DEPTH];
			rd_ptr[lane]++;
		end
	endtask

	// Source answers a request in the following cycle
	task automatic supply_blocks();
		block_payload_t shared;
		block_payload_t pay;
		block_header_t  hdr;
		draw_random(shared);
		for (int lane = 0; lane < LANES; lane++) begin
			case (row_mode[row])
				MODE_ZERO: pay = '0;
				MODE_RAND: draw_random(pay);
				default: begin
					pay = shared;
					if (lane == CHANGED_LANE && blocks_sent >= row_blocks[row] / 2) begin
						pay = shared ^ 64'h5a5a_0ff0_c33c_a55a;
					end
				end
			endcase
			hdr = SYNC_DATA;
			if (row_hdr[row] == HDR_CTRL) begin
				hdr = SYNC_CTRL;
			end else if (row_hdr[row] == HDR_MIXED) begin
				lcg_state = lcg_next(lcg_state);
				if (lcg_state[20]) begin
					hdr = SYNC_CTRL;
				end
			end
			block_header[lane]  = hdr;
			block_payload[lane] = pay;
			push_block(lane, hdr, pay);
		end
		blocks_sent++;
	endtask

	// One clock: check request pattern and outputs, then drive
	task automatic run_cycle();
		serdes_word_t exp_word;
		logic         exp_req;
		int           pos;
		@(posedge clk);
		#1;
		cycle++;
		if (first_req_cycle < 0 && block_req === 1'b1) begin
			first_req_cycle = cycle;
			req_in_window   = 0;
		end
		if (first_req_cycle >= 0) begin
			// 32 requests two cycles apart, then a four-cycle gap
			pos     = (cycle - first_req_cycle) % FRAME_CYCLES;
			exp_req = (pos % 2 == 0) && (pos != FRAME_CYCLES - 2);
			if (block_req !== exp_req) begin
				$display("[FAIL] %s block_req pos %0d expected %b actual %b",
					row_name[row], pos, exp_req, block_req);
				errors++;
			end
			if (block_req === 1'b1) begin
				req_in_window++;
			end
			if (pos == FRAME_CYCLES - 1) begin
				if (req_in_window != FRAME_BLOCKS) begin
					$display("[FAIL] %s requests per frame expected %0d actual %0d",
						row_name[row], FRAME_BLOCKS, req_in_window);
					errors++;
				end
				req_in_window = 0;
			end
		end
		for (int lane = 0; lane < LANES; lane++) begin
			if (first_req_cycle >= 0 && cycle >= first_req_cycle + OUT_LATENCY) begin
				pop_word(lane, exp_word);
			end else begin
				// Idle pipeline emits zeros
				exp_word = '0;
			end
			exp_word = exp_word ^ {SERDES_WIDTH{polarity_inv[lane]}};
			checks++;
			if (serdes_data[lane] !== exp_word) begin
				$display("[FAIL] %s lane %0d cycle %0d expected %h actual %h",
					row_name[row], lane, cycle, exp_word, serdes_data[lane]);
				errors++;
			end
		end
		if (req_prev) begin
			supply_blocks();
		end
		req_prev = block_req;
	endtask

	initial begin
		errors          = 0;
		checks          = 0;
		cycle           = 0;
		first_req_cycle = -1;
		req_in_window   = 0;
		req_prev        = 1'b0;
		aborted         = 1'b0;
		row             = 0;
		blocks_sent     = 0;
		lcg_state       = 32'h84aa_4b5a;
		for (int lane = 0; lane < LANES; lane++) begin
			model_scram[lane] = SCRAM_RESET;
			stream_bits[lane] = '0;
			wr_ptr[lane]      = 0;
			rd_ptr[lane]      = 0;
		end
		load_table();
		rst_n         = 1'b0;
		block_header  = '0;
		block_payload = '0;
		polarity_inv  = row_mask[0];
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst_n = 1'b1;

		// Feeder leaves its reset state within a few cycles
		wait_cnt = 0;
		while (first_req_cycle < 0 && wait_cnt < REQ_TIMEOUT) begin
			run_cycle();
			wait_cnt++;
		end
		if (first_req_cycle < 0) begin
			$display("Timeout: no block request after reset");
			errors++;
			aborted = 1'b1;
		end

		while (row < NUM_ROWS && !aborted) begin
			polarity_inv = row_mask[row];
			blocks_sent  = 0;
			wait_cnt     = 0;
			while (blocks_sent < row_blocks[row] && wait_cnt < 4 * row_blocks[row]) begin
				run_cycle();
				wait_cnt++;
			end
			if (blocks_sent < row_blocks[row]) begin
				$display("Timeout: row %s got too few block requests", row_name[row]);
				errors++;
				aborted = 1'b1;
			end else begin
				row++;
			end
		end

		$display("Done: %0d errors in %0d word checks", errors, checks);
		if (errors == 0 && !aborted) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== logic/gearbox_33_to_32.sv ====
`timescale 1ns/1ps
`default_nettype none

module gearbox_33_to_32 (
	input  wire                       clk,
	input  wire                       rst_n,
	input  wire pcs_pkg::half_word_t  data_in,
	input  wire                       valid_in,
	output serdes_pkg::serdes_word_t  data_out
);

	import pcs_pkg::*;
	import serdes_pkg::*;

	// Working buffer holds up to two output words
	localparam int BUF_WIDTH = 2 * SERDES_WIDTH;
	// Buffer plus the slot that leaves this cycle
	localparam int CMB_WIDTH = BUF_WIDTH + SERDES_WIDTH;
	// Fill count reaches BUF_WIDTH + HALF_WIDTH at most
	localparam int FILL_W    = $clog2(BUF_WIDTH) + 1;

	logic                 valid_in_ff;
	logic [FILL_W-1:0]    fill;
	logic [FILL_W-1:0]    fill_next;
	logic [BUF_WIDTH-1:0] work_buf;
	logic [CMB_WIDTH-1:0] word_aligned;
	logic [CMB_WIDTH-1:0] combined;

	always_comb begin
		// New word placed at the top, zeros below it
		word_aligned = {data_in, {(CMB_WIDTH - HALF_WIDTH){1'b0}}};

		// Buffered bits stay left-justified in the upper part
		combined  = {work_buf, {SERDES_WIDTH{1'b0}}};
		fill_next = fill;

		if (valid_in) begin
			if (!valid_in_ff) begin
				// First word after an idle gap starts a fresh buffer
				combined  = word_aligned;
				fill_next = FILL_W'(HALF_WIDTH);
			end else begin
				// Append right behind the bits already held
				combined  = combined | (word_aligned >> fill);
				fill_next = fill + FILL_W'(HALF_WIDTH);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid_in_ff <= 1'b0;
			fill        <= '0;
			work_buf    <= '0;
			data_out    <= '0;
		end else begin
			valid_in_ff <= valid_in;

			// One word leaves every cycle, valid or not
			fill        <= fill_next - FILL_W'(SERDES_WIDTH);
			work_buf    <= combined[BUF_WIDTH-1:0];

			// MSB of the buffer is the earliest bit
			// Mirror it into bit 0 for the SERDES
			for (int i = 0; i < SERDES_WIDTH; i++) begin
				data_out[i] <= combined[CMB_WIDTH-1-i];
			end
		end
	end

endmodule

`default_nettype wire

// ==== logic/multilane_pcs_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

module multilane_pcs_tx #(
	parameter int LANES = serdes_pkg::DEFAULT_LANES
) (
	input  wire                                      clk,
	input  wire                                      rst_n,
	input  wire pcs_pkg::block_header_t  [LANES-1:0] block_header,
	input  wire pcs_pkg::block_payload_t [LANES-1:0] block_payload,
	input  wire [LANES-1:0]                          polarity_inv,
	output wire                                      block_req,
	output wire serdes_pkg::serdes_word_t [LANES-1:0] serdes_data
);

	import pcs_pkg::*;
	import serdes_pkg::*;

	// Registered blocks, one per lane
	block_header_t  [LANES-1:0] lane_header;
	block_payload_t [LANES-1:0] lane_payload;
	// Shared cadence strobes
	wire                        block_load;
	wire                        half_valid;
	// Gearbox output of every lane
	serdes_word_t   [LANES-1:0] lane_word;

	// Cadence and block capture for all lanes
	tx_block_feeder #(
		.LANES (LANES)
	) u_feeder (
		.clk           (clk),
		.rst_n         (rst_n),
		.block_header  (block_header),
		.block_payload (block_payload),
		.block_req     (block_req),
		.lane_header   (lane_header),
		.lane_payload  (lane_payload),
		.block_load    (block_load),
		.half_valid    (half_valid)
	);

	// Lanes run in lockstep off the same strobes
	for (genvar i = 0; i < LANES; i++) begin : u_lane
		tx_lane u_tx_lane (
			.clk        (clk),
			.rst_n      (rst_n),
			.header     (lane_header[i]),
			.payload    (lane_payload[i]),
			.block_load (block_load),
			.half_valid (half_valid),
			.lane_word  (lane_word[i])
		);
	end

	// Polarity and output register
	tx_lane_bond #(
		.LANES (LANES)
	) u_bond (
		.clk          (clk),
		.rst_n        (rst_n),
		.lane_words   (lane_word),
		.polarity_inv (polarity_inv),
		.serdes_data  (serdes_data)
	);

endmodule

`default_nettype wire

// ==== logic/pcs_pkg.sv ====
`default_nettype none

package pcs_pkg;

	// Field widths of one 64b/66b block
	localparam int HEADER_WIDTH  = 2;
	localparam int PAYLOAD_WIDTH = 64;
	localparam int BLOCK_WIDTH   = HEADER_WIDTH + PAYLOAD_WIDTH;

	// Each block goes to the gearbox as two equal halves
	localparam int HALF_WIDTH    = BLOCK_WIDTH / 2;

	// History length of the x^58 + x^39 + 1 scrambler
	localparam int SCRAM_WIDTH   = 58;

	typedef logic [HEADER_WIDTH-1:0]  block_header_t;
	typedef logic [PAYLOAD_WIDTH-1:0] block_payload_t;
	typedef logic [HALF_WIDTH-1:0]    half_word_t;
	typedef logic [SCRAM_WIDTH-1:0]   scram_state_t;

	// Legal sync headers, bit 0 is the first bit on the line
	// Data block sends 0 then 1
	localparam block_header_t SYNC_DATA = 2'b10;
	// Control block sends 1 then 0
	localparam block_header_t SYNC_CTRL = 2'b01;

	// Scrambler history after reset
	localparam scram_state_t SCRAM_RESET = '1;

	// Gearbox cadence
	// 32 blocks of 66 bits fill 66 words of 32 bits
	localparam int FRAME_CYCLES = 66;
	localparam int FRAME_BLOCKS = 32;

endpackage

`default_nettype wire

// ==== logic/serdes_pkg.sv ====
`default_nettype none

package serdes_pkg;

	// Parallel width of one SERDES lane
	localparam int SERDES_WIDTH = 32;

	// One lane word, bit 0 is sent first
	typedef logic [SERDES_WIDTH-1:0] serdes_word_t;

	// Lane count when the top level is not overridden
	localparam int DEFAULT_LANES = 4;

endpackage

`default_nettype wire

// ==== logic/tx_block_feeder.sv ====
`timescale 1ns/1ps
`default_nettype none

module tx_block_feeder #(
	parameter int LANES = serdes_pkg::DEFAULT_LANES
) (
	input  wire                                      clk,
	input  wire                                      rst_n,
	input  wire pcs_pkg::block_header_t  [LANES-1:0] block_header,
	input  wire pcs_pkg::block_payload_t [LANES-1:0] block_payload,
	output logic                                     block_req,
	output pcs_pkg::block_header_t       [LANES-1:0] lane_header,
	output pcs_pkg::block_payload_t      [LANES-1:0] lane_payload,
	output logic                                     block_load,
	output logic                                     half_valid
);

	import pcs_pkg::*;

	localparam int CNT_W       = $clog2(FRAME_CYCLES);
	// Two half-words per block, then the idle cycles
	localparam int HALF_CYCLES = 2 * FRAME_BLOCKS;

	typedef enum logic {
		ST_RESET,
		ST_RUN
	} feed_state_t;

	feed_state_t      state;
	logic [CNT_W-1:0] frame_cnt;
	logic [CNT_W-1:0] cnt_next;
	logic             req_next;
	// High in the cycle the source drives its data
	logic             capture;

	always_comb begin
		// Frame counter wraps after the two idle cycles
		if (frame_cnt == CNT_W'(FRAME_CYCLES - 1)) begin
			cnt_next = '0;
		end else begin
			cnt_next = frame_cnt + 1'b1;
		end

		// Request three cycles ahead of each first half
		// Odd cycles only, 61 would be a 33rd block
		req_next = cnt_next[0] && (cnt_next != CNT_W'(HALF_CYCLES - 3));
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state      <= ST_RESET;
			// Preload so the first request falls on cycle 63
			// Block 0 then meets half_valid at cycle 0
			frame_cnt  <= CNT_W'(FRAME_CYCLES - 4);
			block_req  <= 1'b0;
			capture    <= 1'b0;
			block_load <= 1'b0;
			half_valid <= 1'b0;
		end else begin
			// Request, then source data, then load
			capture    <= block_req;
			block_load <= capture;

			case (state)
				ST_RESET: begin
					state     <= ST_RUN;
					// First request goes out now
					// half_valid stays low, no block is held yet
					frame_cnt <= cnt_next;
					block_req <= req_next;
				end
				ST_RUN: begin
					frame_cnt  <= cnt_next;
					block_req  <= req_next;
					// Half-words flow in cycles 0 to 63
					half_valid <= (cnt_next < CNT_W'(HALF_CYCLES));
				end
				default: begin
					state <= ST_RESET;
				end
			endcase
		end
	end

	// All lanes sampled on the same edge
	always_ff @(posedge clk) begin
		if (capture) begin
			lane_header  <= block_header;
			lane_payload <= block_payload;
		end
	end

endmodule

`default_nettype wire

// ==== logic/tx_lane.sv ====
`timescale 1ns/1ps
`default_nettype none

module tx_lane (
	input  wire                          clk,
	input  wire                          rst_n,
	input  wire pcs_pkg::block_header_t  header,
	input  wire pcs_pkg::block_payload_t payload,
	input  wire                          block_load,
	input  wire                          half_valid,
	output wire serdes_pkg::serdes_word_t lane_word
);

	import pcs_pkg::*;

	// Taps for x^39 and x^58, index 0 is the newest bit
	localparam int TAP_39 = 38;
	localparam int TAP_58 = 57;

	scram_state_t   scram_state;
	scram_state_t   scram_next;
	block_payload_t payload_scr;
	block_header_t  hold_header;
	block_payload_t hold_payload;
	// Low for the first half, high for the second
	logic           half_sel;
	half_word_t     first_half;
	half_word_t     second_half;
	half_word_t     gb_in;

	// Earliest bit moves to the MSB for the gearbox
	function automatic half_word_t mirror_half(input logic [HALF_WIDTH-1:0] bits);
		half_word_t flipped;
		for (int k = 0; k < HALF_WIDTH; k++) begin
			flipped[HALF_WIDTH-1-k] = bits[k];
		end
		return flipped;
	endfunction

	// Self-synchronous scrambler, payload bit 0 first
	always_comb begin
		scram_next = scram_state;
		for (int i = 0; i < PAYLOAD_WIDTH; i++) begin
			payload_scr[i] = payload[i] ^ scram_next[TAP_39] ^ scram_next[TAP_58];
			// History is fed with scrambled bits
			scram_next     = {scram_next[SCRAM_WIDTH-2:0], payload_scr[i]};
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			scram_state <= SCRAM_RESET;
		end else if (block_load) begin
			scram_state <= scram_next;
		end
	end

	// Block held for its two half-word cycles
	// Header bypasses the scrambler
	always_ff @(posedge clk) begin
		if (block_load) begin
			hold_header  <= header;
			hold_payload <= payload_scr;
		end
	end

	// Parity toggle restarts with every new block
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			half_sel <= 1'b0;
		end else if (block_load) begin
			half_sel <= 1'b0;
		end else if (half_valid) begin
			half_sel <= ~half_sel;
		end
	end

	always_comb begin
		// Header first, then payload bits 0 to 30
		first_half  = mirror_half({hold_payload[HALF_WIDTH-HEADER_WIDTH-1:0], hold_header});
		// Payload bits 31 to 63
		second_half = mirror_half(hold_payload[PAYLOAD_WIDTH-1 -: HALF_WIDTH]);
		gb_in       = half_sel ? second_half : first_half;
	end

	gearbox_33_to_32 u_gearbox (
		.clk      (clk),
		.rst_n    (rst_n),
		.data_in  (gb_in),
		.valid_in (half_valid),
		.data_out (lane_word)
	);

endmodule

`default_nettype wire

// ==== logic/tx_lane_bond.sv ====
`timescale 1ns/1ps
`default_nettype none

module tx_lane_bond #(
	parameter int LANES = serdes_pkg::DEFAULT_LANES
) (
	input  wire                                     clk,
	input  wire                                     rst_n,
	input  wire serdes_pkg::serdes_word_t [LANES-1:0] lane_words,
	input  wire [LANES-1:0]                         polarity_inv,
	output serdes_pkg::serdes_word_t      [LANES-1:0] serdes_data
);

	import serdes_pkg::*;

	// Final register towards the SERDES
	// Lane i occupies word i of the bus
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			serdes_data <= '0;
		end else begin
			for (int i = 0; i < LANES; i++) begin
				// Inverted lanes compensate swapped P/N board traces
				serdes_data[i] <= lane_words[i] ^ {SERDES_WIDTH{polarity_inv[i]}};
			end
		end
	end

endmodule

`default_nettype wire
